//--- source/rv32_types.sv
package rv32_types;

    // Machine word and byte address
    typedef logic [31:0] rv32_word;
    typedef logic [31:0] rv32_addr;

    // Core-side request
    // valid lasts a single cycle, one request outstanding per port
    typedef struct packed {
        logic       valid;
        logic       write;
        rv32_addr   addr;
        rv32_word   wdata;
        // One bit per byte lane of wdata
        logic [3:0] strobe;
    } memory_request_t;

endpackage

//--- source/rv32_memory_map.sv
package rv32_memory_map;

    // RAM region
    localparam rv32_types::rv32_addr RAM_BASE = 32'h0000_0000;
    localparam int RAM_WORDS = 1024;
    localparam int RAM_INDEX_BITS = $clog2(RAM_WORDS);
    localparam rv32_types::rv32_addr RAM_LIMIT = RAM_BASE + RAM_WORDS * 4;

    // Initial RAM contents
    localparam string MEM_IMAGE = "source/rv32_mem_image.hex";

    // MMIO region, one fixed window per device
    localparam int NUM_MMIO = 4;
    localparam rv32_types::rv32_addr MMIO_BASE = 32'h8000_0000;
    localparam int MMIO_SPAN = 32'h100;
    localparam int MMIO_SPAN_BITS = $clog2(MMIO_SPAN);
    localparam rv32_types::rv32_addr MMIO_LIMIT = MMIO_BASE + NUM_MMIO * MMIO_SPAN;

    typedef logic [$clog2(NUM_MMIO)-1:0] mmio_index_t;

endpackage

//--- source/rv32_main_memory.sv
`timescale 1ns/1ps

module rv32_main_memory (
    input  logic                        clk,
    input  logic                        resetn,
    // Instruction port
    input  rv32_types::memory_request_t instr_request,
    output logic                        instr_ready,
    output rv32_types::rv32_word        instr,
    // Data port
    input  rv32_types::memory_request_t data_request,
    input  logic                        mem_select,
    output logic                        data_ready,
    output rv32_types::rv32_word        data
);

    import rv32_types::*;
    import rv32_memory_map::*;

    rv32_word                  ram [RAM_WORDS];
    logic [RAM_INDEX_BITS-1:0] instr_index;
    logic [RAM_INDEX_BITS-1:0] data_index;
    logic                      data_access;

    // Byte address to word slot inside the RAM region
    function automatic logic [RAM_INDEX_BITS-1:0] word_index(input rv32_addr addr);
        rv32_addr offset;
        offset = addr - RAM_BASE;
        return offset[2 +: RAM_INDEX_BITS];
    endfunction

    initial begin
        $readmemh(MEM_IMAGE, ram);
    end

    assign instr_index = word_index(instr_request.addr);
    assign data_index  = word_index(data_request.addr);

    // Decoder has already checked the region
    assign data_access = data_request.valid && mem_select;

    // Instruction port, read only
    always_ff @(posedge clk) begin
        if (!resetn) begin
            instr_ready <= 1'b0;
        end else begin
            instr_ready <= instr_request.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_request.valid) begin
            instr <= ram[instr_index];
        end
    end

    // Data port
    always_ff @(posedge clk) begin
        if (!resetn) begin
            data_ready <= 1'b0;
        end else begin
            data_ready <= data_access;
        end
    end

    // Writes merge byte lanes, reads keep their word until the next read
    always_ff @(posedge clk) begin
        if (data_access) begin
            if (data_request.write) begin
                for (int lane = 0; lane < 4; lane++) begin
                    if (data_request.strobe[lane]) begin
                        ram[data_index][8*lane +: 8] <= data_request.wdata[8*lane +: 8];
                    end
                end
            end else begin
                data <= ram[data_index];
            end
        end
    end

    // Fetch port has no write path
    assert property (@(posedge clk) disable iff (!resetn)
        instr_request.valid |-> !instr_request.write);

    // One outstanding request, so no access can land on the done cycle
    assert property (@(posedge clk) disable iff (!resetn)
        data_access |=> !data_access);

endmodule

//--- source/rv32_mmio_decoder.sv
`timescale 1ns/1ps

module rv32_mmio_decoder (
    input  rv32_types::memory_request_t data_request,
    output logic                        mem_select,
    output logic                        mmio_select [rv32_memory_map::NUM_MMIO]
);

    import rv32_types::*;
    import rv32_memory_map::*;

    rv32_addr    mmio_offset;
    mmio_index_t device;
    logic        in_ram;
    logic        in_mmio;

    // Region compare on the full byte address
    assign in_ram  = (data_request.addr >= RAM_BASE) && (data_request.addr < RAM_LIMIT);
    assign in_mmio = (data_request.addr >= MMIO_BASE) && (data_request.addr < MMIO_LIMIT);

    // Device field sits right above the per-device window
    assign mmio_offset = data_request.addr - MMIO_BASE;
    assign device      = mmio_offset[MMIO_SPAN_BITS +: $bits(mmio_index_t)];

    // Selects only live during the request cycle
    assign mem_select = data_request.valid && in_ram;

    always_comb begin
        for (int idx = 0; idx < NUM_MMIO; idx++) begin
            mmio_select[idx] = data_request.valid && in_mmio
                               && (device == mmio_index_t'(idx));
        end
    end

endmodule

//--- source/rv32_bus_controller.sv
`timescale 1ns/1ps

module rv32_bus_controller (
    input  logic                 clk,
    input  logic                 resetn,
    // Main memory completion
    input  logic                 mem_data_ready,
    input  rv32_types::rv32_word memory_data,
    // MMIO completions
    input  logic                 mmio_request_done [rv32_memory_map::NUM_MMIO],
    input  rv32_types::rv32_word mmio_data [rv32_memory_map::NUM_MMIO],
    // Core data response
    output logic                 core_data_ready,
    output rv32_types::rv32_word core_data
);

    import rv32_memory_map::*;

    logic select_memory;
    logic mmio_selector [NUM_MMIO];
    int   done_count;

    // Ready is an OR of every completion source
    always_comb begin
        core_data_ready = mem_data_ready;
        done_count      = int'(mem_data_ready);
        for (int idx = 0; idx < NUM_MMIO; idx++) begin
            if (mmio_request_done[idx]) begin
                core_data_ready = 1'b1;
                done_count++;
            end
        end
    end

    // Remember which source completed, data follows one cycle later
    always_ff @(posedge clk) begin
        if (!resetn) begin
            select_memory <= 1'b0;
            mmio_selector <= '{default: 1'b0};
        end else begin
            select_memory <= mem_data_ready;
            for (int idx = 0; idx < NUM_MMIO; idx++) begin
                mmio_selector[idx] <= mmio_request_done[idx];
            end
        end
    end

    // Memory wins, then the highest MMIO index
    always_comb begin
        core_data = memory_data;
        if (!select_memory) begin
            for (int idx = 0; idx < NUM_MMIO; idx++) begin
                if (mmio_selector[idx]) begin
                    core_data = mmio_data[idx];
                end
            end
        end
    end

    // One outstanding data request means never two completions together
    assert property (@(posedge clk) disable iff (!resetn) done_count <= 1);

endmodule

//--- source/rv32_memory_top.sv
`timescale 1ns/1ps

module rv32_memory_top (
    input  logic                        clk,
    input  logic                        resetn,
    // Core instruction port
    input  rv32_types::memory_request_t instr_request,
    output logic                        instr_done,
    output rv32_types::rv32_word        instr,
    // Core data port
    input  rv32_types::memory_request_t data_request,
    output logic                        data_done,
    output rv32_types::rv32_word        data,
    // MMIO devices
    output rv32_types::memory_request_t mmio_request,
    output logic                        mmio_select [rv32_memory_map::NUM_MMIO],
    input  logic                        mmio_done [rv32_memory_map::NUM_MMIO],
    input  rv32_types::rv32_word        mmio_data [rv32_memory_map::NUM_MMIO]
);

    import rv32_types::*;

    logic     mem_select;
    logic     mem_data_ready;
    rv32_word memory_data;

    // Devices see the core data request as is
    assign mmio_request = data_request;

    rv32_main_memory memory (
        .clk          (clk),
        .resetn       (resetn),
        .instr_request(instr_request),
        .instr_ready  (instr_done),
        .instr        (instr),
        .data_request (data_request),
        .mem_select   (mem_select),
        .data_ready   (mem_data_ready),
        .data         (memory_data)
    );

    rv32_mmio_decoder decoder (
        .data_request(data_request),
        .mem_select  (mem_select),
        .mmio_select (mmio_select)
    );

    // Merges memory and device completions for the core
    rv32_bus_controller bus (
        .clk              (clk),
        .resetn           (resetn),
        .mem_data_ready   (mem_data_ready),
        .memory_data      (memory_data),
        .mmio_request_done(mmio_done),
        .mmio_data        (mmio_data),
        .core_data_ready  (data_done),
        .core_data        (data)
    );

endmodule

//--- verif/tb_rv32_memory_model.svh
`ifndef TB_RV32_MEMORY_MODEL_SVH
`define TB_RV32_MEMORY_MODEL_SVH

localparam logic [15:0] LFSR_SEED = 16'd61201;

logic [15:0] lfsr_state = LFSR_SEED;

// Reference RAM, same image as the DUT
rv32_word ref_ram [RAM_WORDS];

initial begin
    $readmemh(MEM_IMAGE, ref_ram);
end

// Fibonacci LFSR, taps 16 14 13 11, one step per bit
function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = '0;
    for (int n = 0; n < count; n++) begin
        feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        value      = {value[30:0], feedback};
    end
    return value;
endfunction

function automatic rv32_addr ram_addr(input int slot);
    return RAM_BASE + rv32_addr'(slot) * 4;
endfunction

function automatic int ram_slot(input rv32_addr addr);
    return int'((addr - RAM_BASE) >> 2);
endfunction

// Byte lanes with a strobe bit take the new data
function automatic rv32_word merge_bytes(input rv32_word old_word, input rv32_word wdata,
                                         input logic [3:0] strobe);
    rv32_word merged;
    merged = old_word;
    for (int lane = 0; lane < 4; lane++) begin
        if (strobe[lane]) begin
            merged[8*lane +: 8] = wdata[8*lane +: 8];
        end
    end
    return merged;
endfunction

// Device index in the top byte, low address bits below
function automatic rv32_word mmio_value(input int device, input rv32_addr addr);
    return {8'(device), addr[23:0]};
endfunction

`endif

//--- verif/tb_rv32_memory_top.sv
`timescale 1ns/1ps

module tb_rv32_memory_top;

    import rv32_types::*;
    import rv32_memory_map::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int FETCH_TESTS    = 40;
    localparam int RAM_TESTS      = 30;
    localparam int MMIO_TESTS     = 30;
    localparam int MIXED_TESTS    = 24;

    logic            clk;
    logic            resetn;
    memory_request_t instr_request;
    logic            instr_done;
    rv32_word        instr;
    memory_request_t data_request;
    logic            data_done;
    rv32_word        data;
    memory_request_t mmio_request;
    logic            mmio_select [NUM_MMIO];
    logic            mmio_done [NUM_MMIO];
    rv32_word        mmio_data [NUM_MMIO];

    int error_count     = 0;
    int test_count      = 0;
    int fetch_count     = 0;
    int data_count      = 0;
    int instr_done_seen = 0;
    int data_done_seen  = 0;

    `include "tb_rv32_memory_model.svh"

    rv32_memory_top uut (
        .clk          (clk),
        .resetn       (resetn),
        .instr_request(instr_request),
        .instr_done   (instr_done),
        .instr        (instr),
        .data_request (data_request),
        .data_done    (data_done),
        .data         (data),
        .mmio_request (mmio_request),
        .mmio_select  (mmio_select),
        .mmio_done    (mmio_done),
        .mmio_data    (mmio_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic void report_mismatch(input string message);
        $display("FAILED %0t ns: %s", $time, message);
        error_count++;
    endfunction

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s did not arrive within %0d cycles, at %0t ns",
                 what, TIMEOUT_CYCLES, $time);
        $display("*** FAILED ***");
        $finish;
    endtask

    function automatic logic any_select();
        for (int k = 0; k < NUM_MMIO; k++) begin
            if (mmio_select[k] !== 1'b0) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic finish_test(input int number, input string name, input int requests,
                               input int errors_before);
        $display("Test %0d %s: %0d requests, %0d errors", number, name, requests,
                 error_count - errors_before);
        test_count++;
    endtask

    // Devices answer 1 to 4 cycles after their select
    for (genvar k = 0; k < NUM_MMIO; k++) begin : responder
        initial begin
            int       delay;
            rv32_addr addr;
            mmio_done[k] = 1'b0;
            mmio_data[k] = '0;
            forever begin
                @(posedge clk);
                if (resetn === 1'b1 && mmio_select[k] === 1'b1) begin
                    addr  = mmio_request.addr;
                    delay = 1 + int'(random_bits(2));
                    repeat (delay) @(posedge clk);
                    mmio_done[k] <= 1'b1;
                    mmio_data[k] <= mmio_value(k, addr);
                    @(posedge clk);
                    mmio_done[k] <= 1'b0;
                    // Data is held one more cycle, then spoiled
                    @(posedge clk);
                    mmio_data[k] <= ~mmio_value(k, addr);
                end
            end
        end
    end

    // Counts every completion, requested or not
    always @(posedge clk) begin
        if (resetn === 1'b1) begin
            if (instr_done === 1'b1) instr_done_seen++;
            if (data_done === 1'b1) data_done_seen++;
        end
    end

    task automatic fetch_word(input int slot);
        rv32_word expected;
        int       waited;
        instr_request <= '{valid: 1'b1, write: 1'b0, addr: ram_addr(slot), wdata: '0,
                           strobe: 4'h0};
        @(posedge clk);
        instr_request.valid <= 1'b0;
        expected = ref_ram[slot];
        waited   = 1;
        @(posedge clk);
        while (instr_done !== 1'b1) begin
            if (waited >= TIMEOUT_CYCLES) stop_on_timeout("instr_done after a fetch");
            waited++;
            @(posedge clk);
        end
        if (waited != 1) begin
            report_mismatch($sformatf("fetch slot %0d took %0d cycles", slot, waited));
        end
        if (instr !== expected) begin
            report_mismatch($sformatf("fetch slot %0d: instr %h, expected %h",
                                      slot, instr, expected));
        end
        fetch_count++;
    endtask

    // device below zero means a RAM access
    task automatic access_data(input logic is_write, input rv32_addr addr, input rv32_word wdata,
                               input logic [3:0] strobe, input int device);
        rv32_word expected;
        int       waited;
        int       slot;
        data_request <= '{valid: 1'b1, write: is_write, addr: addr, wdata: wdata, strobe: strobe};
        @(posedge clk);
        data_request.valid <= 1'b0;
        for (int k = 0; k < NUM_MMIO; k++) begin
            if (mmio_select[k] !== (k == device)) begin
                report_mismatch($sformatf("addr %h: mmio_select[%0d] is %b", addr, k,
                                          mmio_select[k]));
            end
        end
        // Devices see the request exactly as the core issued it
        if (mmio_request !== data_request) begin
            report_mismatch($sformatf("addr %h: mmio_request %h differs from request", addr,
                                      mmio_request));
        end
        if (device < 0) begin
            slot = ram_slot(addr);
            if (is_write) ref_ram[slot] = merge_bytes(ref_ram[slot], wdata, strobe);
            expected = ref_ram[slot];
        end else begin
            expected = mmio_value(device, addr);
        end
        waited = 1;
        @(posedge clk);
        if (any_select()) report_mismatch($sformatf("addr %h: select held past request", addr));
        while (data_done !== 1'b1) begin
            if (waited >= TIMEOUT_CYCLES) stop_on_timeout("data_done after a data request");
            waited++;
            @(posedge clk);
        end
        if (device < 0 && waited != 1) begin
            report_mismatch($sformatf("RAM access %h took %0d cycles", addr, waited));
        end
        if (device >= 0 && mmio_done[device] !== 1'b1) begin
            report_mismatch($sformatf("data_done without done of device %0d", device));
        end
        @(posedge clk);
        if (!is_write && data !== expected) begin
            report_mismatch($sformatf("read %h: data %h, expected %h", addr, data, expected));
        end
        data_count++;
    endtask

    initial begin
        int errors_before;
        int slot;
        int device;
        resetn        = 1'b0;
        instr_request = '0;
        data_request  = '0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        errors_before = error_count;
        repeat (5) begin
            @(posedge clk);
            if (instr_done !== 1'b0 || data_done !== 1'b0 || any_select()) begin
                report_mismatch("done or select active after reset");
            end
        end
        finish_test(1, "reset", 0, errors_before);

        errors_before = error_count;
        repeat (FETCH_TESTS) fetch_word(random_bits(6));
        finish_test(2, "instruction fetch", FETCH_TESTS, errors_before);

        // Write, read back on the data port, then fetch the same word
        errors_before = error_count;
        repeat (RAM_TESTS) begin
            slot = random_bits(6);
            access_data(1'b1, ram_addr(slot), random_bits(32), 4'(random_bits(4)), -1);
            access_data(1'b0, ram_addr(slot), '0, 4'h0, -1);
            fetch_word(slot);
        end
        finish_test(3, "RAM data access", 3 * RAM_TESTS, errors_before);

        errors_before = error_count;
        repeat (MMIO_TESTS) begin
            device = random_bits(2);
            access_data(1'b0, MMIO_BASE + device * MMIO_SPAN + random_bits(6) * 4, '0, 4'h0,
                        device);
        end
        finish_test(4, "MMIO access", MMIO_TESTS, errors_before);

        // Fetches use words 0 to 31, data traffic words 32 to 63
        errors_before = error_count;
        fork
            repeat (MIXED_TESTS) fetch_word(random_bits(5));
            for (int i = 0; i < MIXED_TESTS; i++) begin
                if (i % 2 == 0) begin
                    access_data(1'(random_bits(1)), ram_addr(32 + random_bits(5)),
                                random_bits(32), 4'(random_bits(4)), -1);
                end else begin
                    device = random_bits(2);
                    access_data(1'b0, MMIO_BASE + device * MMIO_SPAN + random_bits(6) * 4, '0,
                                4'h0, device);
                end
            end
        join
        repeat (3) @(posedge clk);
        if (instr_done_seen != fetch_count || data_done_seen != data_count) begin
            report_mismatch($sformatf("dones %0d/%0d for requests %0d/%0d", instr_done_seen,
                                      data_done_seen, fetch_count, data_count));
        end
        finish_test(5, "mixed traffic", 2 * MIXED_TESTS, errors_before);

        $display("Summary: %0d tests, %0d fetches, %0d data accesses, %0d errors",
                 test_count, fetch_count, data_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- source/rv32_mem_image.hex
// One 32-bit word per entry, eight per line, word k at byte address 4*k
// Low half holds the byte address of the word, words above 63 stay unloaded
C0DE0000 C0DE0004 C0DE0008 C0DE000C C0DE0010 C0DE0014 C0DE0018 C0DE001C
C0DE0020 C0DE0024 C0DE0028 C0DE002C C0DE0030 C0DE0034 C0DE0038 C0DE003C
C0DE0040 C0DE0044 C0DE0048 C0DE004C C0DE0050 C0DE0054 C0DE0058 C0DE005C
C0DE0060 C0DE0064 C0DE0068 C0DE006C C0DE0070 C0DE0074 C0DE0078 C0DE007C
C0DE0080 C0DE0084 C0DE0088 C0DE008C C0DE0090 C0DE0094 C0DE0098 C0DE009C
C0DE00A0 C0DE00A4 C0DE00A8 C0DE00AC C0DE00B0 C0DE00B4 C0DE00B8 C0DE00BC
C0DE00C0 C0DE00C4 C0DE00C8 C0DE00CC C0DE00D0 C0DE00D4 C0DE00D8 C0DE00DC
C0DE00E0 C0DE00E4 C0DE00E8 C0DE00EC C0DE00F0 C0DE00F4 C0DE00F8 C0DE00FC

//--- verilog.f
+incdir+verif
source/rv32_types.sv
source/rv32_memory_map.sv
source/rv32_main_memory.sv
source/rv32_mmio_decoder.sv
source/rv32_bus_controller.sv
source/rv32_memory_top.sv
verif/tb_rv32_memory_top.sv
